// ==== Bender.yml ====
package:
  name: des_core

sources:
  - source/des_pkg.sv
  - source/des_round.sv
  - source/des_round_stage.sv
  - source/des_key_schedule.sv
  - source/des_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/des_core_tb.sv

// ==== filelist.f ====
+incdir+tests
source/des_pkg.sv
source/des_round.sv
source/des_round_stage.sv
source/des_key_schedule.sv
source/des_core.sv
tests/des_core_tb.sv

// ==== source/des_core.sv ====
module des_core (
    input  logic            ck,
    input  logic            rst,
    input  logic            key_load,
    input  des_pkg::block_t key,
    input  logic            decrypt,
    input  logic            data_valid,
    input  des_pkg::block_t data_in,
    output logic            out_valid,
    output des_pkg::block_t data_out
);

    des_pkg::subkey_bank_t first_keys;
    des_pkg::subkey_bank_t second_keys;
    des_pkg::block_t       ip_next;
    des_pkg::block_t       ip_block;
    logic                  ip_valid;
    des_pkg::block_t       mid_block;
    logic                  mid_valid;
    des_pkg::block_t       last_block;
    logic                  last_valid;
    des_pkg::block_t       preoutput;
    des_pkg::block_t       fp_next;

    // **************************************************
    // Initial permutation
    // **************************************************

    always_comb begin
        for (int i = 0; i < des_pkg::block_w; i++) begin
            ip_next[des_pkg::block_w-1-i] = data_in[des_pkg::block_w - des_pkg::ip_table[i]];
        end
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            ip_valid <= 1'b0;
        end else begin
            ip_valid <= data_valid;
        end
    end

    always_ff @(posedge ck) begin
        if (data_valid) begin
            ip_block <= ip_next;
        end
    end

    des_key_schedule i_key_schedule (
        .ck          (ck),
        .rst         (rst),
        .key_load    (key_load),
        .key         (key),
        .decrypt     (decrypt),
        .first_keys  (first_keys),
        .second_keys (second_keys)
    );

    des_round_stage i_stage_first (
        .ck        (ck),
        .rst       (rst),
        .in_valid  (ip_valid),
        .block_in  (ip_block),
        .keys      (first_keys),
        .out_valid (mid_valid),
        .block_out (mid_block)
    );

    des_round_stage i_stage_second (
        .ck        (ck),
        .rst       (rst),
        .in_valid  (mid_valid),
        .block_in  (mid_block),
        .keys      (second_keys),
        .out_valid (last_valid),
        .block_out (last_block)
    );

    // **************************************************
    // Final permutation
    // **************************************************

    // Round 16 does not swap, so its swap is taken back here.
    assign preoutput = {last_block[des_pkg::half_w-1:0],
                        last_block[des_pkg::block_w-1 -: des_pkg::half_w]};

    always_comb begin
        for (int i = 0; i < des_pkg::block_w; i++) begin
            fp_next[des_pkg::block_w-1-i] = preoutput[des_pkg::block_w - des_pkg::fp_table[i]];
        end
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= last_valid;
        end
    end

    always_ff @(posedge ck) begin
        if (last_valid) begin
            data_out <= fp_next;
        end
    end

endmodule

// ==== source/des_key_schedule.sv ====
module des_key_schedule (
    input  logic                  ck,
    input  logic                  rst,
    input  logic                  key_load,
    input  des_pkg::block_t       key,
    input  logic                  decrypt,
    output des_pkg::subkey_bank_t first_keys,
    output des_pkg::subkey_bank_t second_keys
);

    des_pkg::key_phase_e   phase;
    des_pkg::cd_t          cd_held;
    logic                  decrypt_held;
    des_pkg::cd_t          cd_walk;
    logic                  walk_mode;
    logic [4:0]            round_base;
    des_pkg::subkey_bank_t bank_next;

    function automatic des_pkg::cd_t permute_pc1(des_pkg::block_t k);
        des_pkg::cd_t cd;
        for (int i = 0; i < des_pkg::cd_w; i++) begin
            cd[des_pkg::cd_w-1-i] = k[des_pkg::block_w - des_pkg::pc1_table[i]];
        end
        return cd;
    endfunction

    function automatic des_pkg::subkey_t permute_pc2(des_pkg::cd_t cd);
        des_pkg::subkey_t sk;
        for (int i = 0; i < des_pkg::subkey_w; i++) begin
            sk[des_pkg::subkey_w-1-i] = cd[des_pkg::cd_w - des_pkg::pc2_table[i]];
        end
        return sk;
    endfunction

    // Decryption walks backwards with right rotations. The total rotation over
    // sixteen rounds is 28, so round 16 uses the unrotated PC-1 output.
    function automatic des_pkg::cd_t step(des_pkg::cd_t cd, logic [4:0] round, logic dec);
        logic [des_pkg::cd_w/2-1:0] c;
        logic [des_pkg::cd_w/2-1:0] d;
        int unsigned                amount;
        c = cd[des_pkg::cd_w-1 -: des_pkg::cd_w/2];
        d = cd[des_pkg::cd_w/2-1:0];
        if (!dec) begin
            amount = des_pkg::shift_table[round[3:0]];
            c = (c << amount) | (c >> (des_pkg::cd_w/2 - amount));
            d = (d << amount) | (d >> (des_pkg::cd_w/2 - amount));
        end else if (round != 5'd0) begin
            amount = des_pkg::shift_table[4'(5'd16 - round)];
            c = (c >> amount) | (c << (des_pkg::cd_w/2 - amount));
            d = (d >> amount) | (d << (des_pkg::cd_w/2 - amount));
        end
        return {c, d};
    endfunction

    always_comb begin
        if (phase == des_pkg::key_first_half && !key_load) begin
            cd_walk    = cd_held;   // Carry on from the ninth round.
            walk_mode  = decrypt_held;
            round_base = 5'd8;
        end else begin
            cd_walk    = permute_pc1(key);
            walk_mode  = decrypt;
            round_base = 5'd0;
        end
        for (int i = 0; i < des_pkg::rounds_per_stage; i++) begin
            cd_walk      = step(cd_walk, round_base + 5'(i), walk_mode);
            bank_next[i] = permute_pc2(cd_walk);
        end
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            phase <= des_pkg::key_idle;
        end else if (key_load) begin
            phase <= des_pkg::key_first_half;
        end else if (phase == des_pkg::key_first_half) begin
            phase <= des_pkg::key_second_half;  // Both banks are complete.
        end else begin
            phase <= des_pkg::key_idle;
        end
    end

    always_ff @(posedge ck) begin
        if (key_load) begin
            first_keys   <= bank_next;
            cd_held      <= cd_walk;
            decrypt_held <= decrypt;
        end else if (phase == des_pkg::key_first_half) begin
            second_keys <= bank_next;
        end
    end

endmodule

// ==== source/des_pkg.sv ====
package des_pkg;

    // **************************************************
    // Widths and types
    // **************************************************

    localparam int unsigned block_w          = 64;
    localparam int unsigned half_w           = 32;
    localparam int unsigned subkey_w         = 48;
    localparam int unsigned cd_w             = 56;
    localparam int unsigned rounds_per_stage = 8;

    typedef logic [block_w-1:0]  block_t;  // Standard bit 1 sits at bit 63.
    typedef logic [half_w-1:0]   half_t;
    typedef logic [subkey_w-1:0] subkey_t;
    typedef logic [cd_w-1:0]     cd_t;     // C in the upper 28 bits, D in the lower 28.

    typedef logic [rounds_per_stage-1:0][subkey_w-1:0] subkey_bank_t;

    typedef enum logic [1:0] {
        key_idle,
        key_first_half,
        key_second_half
    } key_phase_e;

    // **************************************************
    // Position tables, 1-based as in the standard
    // **************************************************

    localparam int unsigned ip_table [block_w] = '{
        58, 50, 42, 34, 26, 18, 10, 2,
        60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6,
        64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17,  9, 1,
        59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5,
        63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int unsigned fp_table [block_w] = '{
        40, 8, 48, 16, 56, 24, 64, 32,
        39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30,
        37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28,
        35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26,
        33, 1, 41,  9, 49, 17, 57, 25
    };

    localparam int unsigned e_table [subkey_w] = '{
        32,  1,  2,  3,  4,  5,
         4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13,
        12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21,
        20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29,
        28, 29, 30, 31, 32,  1
    };

    localparam int unsigned p_table [half_w] = '{
        16,  7, 20, 21, 29, 12, 28, 17,
         1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9,
        19, 13, 30,  6, 22, 11,  4, 25
    };

    localparam int unsigned pc1_table [cd_w] = '{
        57, 49, 41, 33, 25, 17,  9,
         1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27,
        19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,
         7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29,
        21, 13,  5, 28, 20, 12,  4
    };

    localparam int unsigned pc2_table [subkey_w] = '{
        14, 17, 11, 24,  1,  5,
         3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8,
        16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55,
        30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53,
        46, 42, 50, 36, 29, 32
    };

    localparam int unsigned shift_table [16] = '{
        1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
    };

    // **************************************************
    // S-boxes, indexed by row * 16 + column
    // **************************************************

    localparam logic [3:0] sbox_table [8][64] = '{
        '{
            14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
             0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
             4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
            15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13
        },
        '{
            15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
             3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
             0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
            13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9
        },
        '{
            10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
            13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
            13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
             1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12
        },
        '{
             7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
            13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
            10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
             3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14
        },
        '{
             2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
            14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
             4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
            11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3
        },
        '{
            12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
            10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
             9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
             4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13
        },
        '{
             4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
            13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
             1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
             6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12
        },
        '{
            13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
             1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
             7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
             2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11
        }
    };

endpackage

// ==== source/des_round.sv ====
module des_round (
    input  des_pkg::block_t  block_in,
    input  des_pkg::subkey_t subkey,
    output des_pkg::block_t  block_out
);

    des_pkg::half_t   left;
    des_pkg::half_t   right;
    des_pkg::subkey_t mixed;
    des_pkg::half_t   sbox_out;
    des_pkg::half_t   f_out;

    assign left  = block_in[des_pkg::block_w-1 -: des_pkg::half_w];
    assign right = block_in[des_pkg::half_w-1:0];

    always_comb begin
        for (int i = 0; i < des_pkg::subkey_w; i++) begin
            mixed[des_pkg::subkey_w-1-i] = right[des_pkg::half_w - des_pkg::e_table[i]]
                                         ^ subkey[des_pkg::subkey_w-1-i];
        end
    end

    // Row comes from the outer two bits of each group, column from the inner four.
    always_comb begin
        logic [5:0] chunk;
        for (int k = 0; k < des_pkg::half_w / 4; k++) begin
            chunk = mixed[des_pkg::subkey_w-1-6*k -: 6];
            sbox_out[des_pkg::half_w-1-4*k -: 4] =
                des_pkg::sbox_table[k][{chunk[5], chunk[0], chunk[4:1]}];
        end
    end

    always_comb begin
        for (int i = 0; i < des_pkg::half_w; i++) begin
            f_out[des_pkg::half_w-1-i] = sbox_out[des_pkg::half_w - des_pkg::p_table[i]];
        end
    end

    assign block_out = {right, left ^ f_out};  // Every round swaps the halves.

endmodule

// ==== source/des_round_stage.sv ====
module des_round_stage (
    input  logic                  ck,
    input  logic                  rst,
    input  logic                  in_valid,
    input  des_pkg::block_t       block_in,
    input  des_pkg::subkey_bank_t keys,
    output logic                  out_valid,
    output des_pkg::block_t       block_out
);

    des_pkg::block_t chain [des_pkg::rounds_per_stage+1];

    assign chain[0] = block_in;

    for (genvar r = 0; r < des_pkg::rounds_per_stage; r++) begin : g_round
        des_round i_round (
            .block_in  (chain[r]),
            .subkey    (keys[r]),
            .block_out (chain[r+1])
        );
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge ck) begin
        if (in_valid) begin
            block_out <= chain[des_pkg::rounds_per_stage];
        end
    end

endmodule

// ==== tests/des_vectors.svh ====
// Each row holds a key, the decrypt bit, idle cycles before the block, the input block
// and the expected output.
// Rows that share key and mode form one group and run under a single key load.

typedef struct packed {
    des_pkg::block_t key;
    logic            decrypt;
    logic [3:0]      gap;
    des_pkg::block_t data;
    des_pkg::block_t expected;
} vector_t;

localparam int unsigned vector_count = 13;

localparam vector_t vectors [vector_count] = '{
    '{64'h133457799bbcdff1, 1'b0, 4'd0, 64'h0123456789abcdef, 64'h85e813540f0ab405},
    '{64'h133457799bbcdff1, 1'b1, 4'd0, 64'h85e813540f0ab405, 64'h0123456789abcdef},
    // Four blocks back to back keep the whole pipeline full.
    '{64'h0123456789abcdef, 1'b0, 4'd0, 64'h4e6f772069732074, 64'h3fa40e8a984d4815},
    '{64'h0123456789abcdef, 1'b0, 4'd0, 64'h68652074696d6520, 64'h6a271787ab8883f9},
    '{64'h0123456789abcdef, 1'b0, 4'd0, 64'h666f7220616c6c20, 64'h893d51ec4b563b53},
    '{64'h0123456789abcdef, 1'b0, 4'd0, 64'h4e6f772069732074, 64'h3fa40e8a984d4815},
    // One idle cycle between these blocks.
    '{64'h0123456789abcdef, 1'b1, 4'd0, 64'h3fa40e8a984d4815, 64'h4e6f772069732074},
    '{64'h0123456789abcdef, 1'b1, 4'd1, 64'h6a271787ab8883f9, 64'h68652074696d6520},
    '{64'h0123456789abcdef, 1'b1, 4'd1, 64'h893d51ec4b563b53, 64'h666f7220616c6c20},
    '{64'h0000000000000000, 1'b0, 4'd0, 64'h0000000000000000, 64'h8ca64de9c1b123a7},
    '{64'h0000000000000000, 1'b1, 4'd0, 64'h8ca64de9c1b123a7, 64'h0000000000000000},
    '{64'h0e329232ea6d0d73, 1'b0, 4'd0, 64'h8787878787878787, 64'h0000000000000000},
    '{64'h0e329232ea6d0d73, 1'b1, 4'd0, 64'h0000000000000000, 64'h8787878787878787}
};

// ==== tests/des_core_tb.sv ====
module des_core_tb;

    `include "des_vectors.svh"

    localparam int unsigned reset_cycles   = 8;
    localparam int unsigned pipe_depth     = 4;  // Registers from data_in to data_out.
    localparam int unsigned timeout_cycles = reset_cycles + 8 * vector_count + 50;

    logic            ck = 1'b0;
    logic            rst;
    logic            key_load;
    des_pkg::block_t key;
    logic            decrypt;
    logic            data_valid;
    des_pkg::block_t data_in;
    logic            out_valid;
    des_pkg::block_t data_out;

    des_pkg::block_t expected_in;  // Expected output of the block now on data_in.
    int unsigned     cycle = 0;
    des_pkg::block_t expected_q [$];
    int unsigned     due_q [$];

    des_core i_des_core (
        .ck         (ck),
        .rst        (rst),
        .key_load   (key_load),
        .key        (key),
        .decrypt    (decrypt),
        .data_valid (data_valid),
        .data_in    (data_in),
        .out_valid  (out_valid),
        .data_out   (data_out)
    );

    always #2 ck = ~ck;

    // **************************************************
    // Checking
    // **************************************************

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped at cycle %0d.", cycle);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected 0x%h, got 0x%h at cycle %0d",
                     name, expected, actual, cycle);
            stop_with_failure();
        end
    endtask

    always @(posedge ck) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles.", timeout_cycles);
            stop_with_failure();
        end
    end

    // Outputs are looked at on the falling edge, half a cycle after they change.
    always @(negedge ck) begin
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            check_value("out_valid", 64'd1, {63'd0, out_valid});
            check_value("data_out", expected_q[0], data_out);
            expected_q.delete(0);
            due_q.delete(0);
        end else begin
            check_value("out_valid", 64'd0, {63'd0, out_valid});  // No early, late or extra block.
        end
        if (data_valid === 1'b1) begin
            expected_q.push_back(expected_in);
            due_q.push_back(cycle + pipe_depth);
        end
    end

    // **************************************************
    // Stimulus
    // **************************************************

    function automatic bit starts_new_key(int unsigned row);
        if (row == 0) begin
            return 1'b1;
        end
        return vectors[row].key != vectors[row-1].key
            || vectors[row].decrypt != vectors[row-1].decrypt;
    endfunction

    task automatic wait_for_drain();
        while (due_q.size() != 0) begin
            @(posedge ck);
        end
    endtask

    initial begin
        rst         = 1'b1;
        key_load    = 1'b0;
        key         = '0;
        decrypt     = 1'b0;
        data_valid  = 1'b0;
        data_in     = '0;
        expected_in = '0;
        repeat (reset_cycles) @(posedge ck);
        rst <= 1'b0;

        for (int unsigned i = 0; i < vector_count; i++) begin
            if (starts_new_key(i)) begin
                data_valid <= 1'b0;
                wait_for_drain();  // A new key only once nothing is in flight.
                key_load <= 1'b1;
                key      <= vectors[i].key;
                decrypt  <= vectors[i].decrypt;
                @(posedge ck);
                key_load <= 1'b0;
            end else begin
                repeat (vectors[i].gap) begin
                    data_valid <= 1'b0;
                    @(posedge ck);
                end
            end
            data_valid  <= 1'b1;
            data_in     <= vectors[i].data;
            expected_in <= vectors[i].expected;
            @(posedge ck);
        end

        data_valid <= 1'b0;
        wait_for_drain();
        repeat (2) @(posedge ck);
        $display("PASS: all tests");
        $finish;
    end

endmodule
